//--- rtl/fetch_pkg.sv
package fetch_pkg;

    localparam int XLEN           = 32;
    localparam int LINE_BITS      = 256;
    localparam int BEAT_BITS      = 64;
    localparam int BEATS_PER_LINE = LINE_BITS / BEAT_BITS;
    localparam int NUM_SETS       = 16;
    localparam int QUEUE_DEPTH    = 8;

    // derived address split
    localparam int OFFSET_BITS   = $clog2(LINE_BITS / 8);    // byte offset in a line
    localparam int INDEX_BITS    = $clog2(NUM_SETS);
    localparam int TAG_BITS      = XLEN - INDEX_BITS - OFFSET_BITS;
    localparam int BEAT_SEL_BITS = $clog2(BEATS_PER_LINE);
    localparam int QPTR_BITS     = $clog2(QUEUE_DEPTH);

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fetch_pkt_t;

endpackage

//--- rtl/fetch_ifs.sv
`timescale 1ns/1ps

// fetch unit to icache
interface icache_if import fetch_pkg::*; ();

    logic                 req;
    logic [XLEN-1:0]      addr;
    logic                 resp;
    logic [LINE_BITS-1:0] line;

    modport fetch (output req, output addr, input resp, input line);
    modport cache (input req, input addr, output resp, output line);

endinterface

// icache to line deserializer, one fill in flight
interface fill_if import fetch_pkg::*; ();

    logic                 read;
    logic [XLEN-1:0]      addr;    // line aligned
    logic                 resp;
    logic [LINE_BITS-1:0] line;

    modport cache (output read, output addr, input resp, input line);
    modport mem (input read, input addr, output resp, output line);

endinterface

// fetch unit to instruction queue
interface enq_if import fetch_pkg::*; ();

    logic       enq;
    fetch_pkt_t pkt;
    logic       flush;    // wins over enq
    logic       full;

    modport producer (output enq, output pkt, output flush, input full);
    modport consumer (input enq, input pkt, input flush, output full);

endinterface

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            redirect_i,
    input  logic [XLEN-1:0] redirect_pc_i,
    icache_if.fetch         cache,
    enq_if.producer         queue
);

    logic [XLEN-1:0]             pc;
    logic [XLEN-1:0]             req_addr;
    logic                        req_q;
    logic                        discard;    // outstanding miss belongs to an old pc

    logic [LINE_BITS-1:0]        buf_line;
    logic [XLEN-OFFSET_BITS-1:0] buf_tag;
    logic                        buf_valid;

    logic                        buf_hit;
    logic                        keep_line;
    logic [XLEN-1:0]             cur_word;

    assign buf_hit   = buf_valid && (buf_tag == pc[XLEN-1:OFFSET_BITS]);
    assign keep_line = cache.resp && !discard;
    assign cur_word  = buf_line[pc[OFFSET_BITS-1:2]*XLEN +: XLEN];

    assign cache.req  = req_q;
    assign cache.addr = req_addr;

    // redirect flushes right away, no enqueue in that cycle
    assign queue.flush = redirect_i;
    assign queue.enq   = buf_hit && !queue.full && !redirect_i;
    assign queue.pkt   = '{pc: pc, instr: cur_word};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= RESET_PC;
            req_q     <= 1'b0;
            discard   <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            if (cache.resp) begin
                req_q   <= 1'b0;
                discard <= 1'b0;
            end
            if (keep_line) begin
                buf_valid <= 1'b1;
            end

            if (redirect_i) begin
                pc <= redirect_pc_i;
                if (req_q && !cache.resp) begin
                    discard <= 1'b1;    // let the old miss finish first
                end
            end else if (queue.enq) begin
                pc <= pc + XLEN'(4);
            end else if (!buf_hit && !req_q) begin
                req_q <= 1'b1;          // miss in line buffer
            end
        end
    end

    // request address follows pc until req goes up, then holds
    always_ff @(posedge clk) begin
        if (!req_q) begin
            req_addr <= pc;
        end
        if (keep_line) begin
            buf_line <= cache.line;
            buf_tag  <= req_addr[XLEN-1:OFFSET_BITS];
        end
    end

endmodule

//--- rtl/icache.sv
`timescale 1ns/1ps

module icache
    import fetch_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    icache_if.cache cache,
    fill_if.cache   fill
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_FILL,
        S_RESP
    } state_t;

    state_t state;
    state_t state_next;

    logic [LINE_BITS-1:0]  data_mem [NUM_SETS];
    logic [TAG_BITS-1:0]   tag_mem  [NUM_SETS];
    logic [NUM_SETS-1:0]   valid_q;

    // array read, registered like a sync sram
    logic [LINE_BITS-1:0]  rd_line;
    logic [TAG_BITS-1:0]   rd_tag;
    logic                  rd_valid;

    logic [INDEX_BITS-1:0] idx;
    logic [TAG_BITS-1:0]   tag;
    logic                  hit;
    logic                  fill_done;

    // addr is held stable by the requester until resp
    assign idx = cache.addr[OFFSET_BITS +: INDEX_BITS];
    assign tag = cache.addr[XLEN-1 -: TAG_BITS];

    assign hit       = rd_valid && (rd_tag == tag);
    assign fill_done = (state == S_FILL) && fill.resp;

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (cache.req) begin
                    state_next = S_LOOKUP;
                end
            end
            S_LOOKUP: state_next = hit ? S_RESP : S_FILL;
            S_FILL: begin
                if (fill.resp) begin
                    state_next = S_RESP;
                end
            end
            S_RESP:   state_next = S_IDLE;
            default:  state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            valid_q <= '0;
        end else begin
            state <= state_next;
            if (fill_done) begin
                valid_q[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && cache.req) begin
            rd_line  <= data_mem[idx];
            rd_tag   <= tag_mem[idx];
            rd_valid <= valid_q[idx];
        end
        if (fill_done) begin
            data_mem[idx] <= fill.line;
            tag_mem[idx]  <= tag;
            rd_line       <= fill.line;    // answer straight from the fill
        end
    end

    // one fill per miss, read pulses for a single cycle
    assign fill.read = (state == S_LOOKUP) && !hit;
    assign fill.addr = {cache.addr[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    assign cache.resp = (state == S_RESP);
    assign cache.line = rd_line;

endmodule

//--- rtl/line_deserializer.sv
`timescale 1ns/1ps

module line_deserializer
    import fetch_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    fill_if.mem                  fill,
    output logic [XLEN-1:0]      bmem_addr_o,
    output logic                 bmem_read_o,
    input  logic                 bmem_ready_i,
    input  logic [XLEN-1:0]      bmem_raddr_i,
    input  logic [BEAT_BITS-1:0] bmem_rdata_i,
    input  logic                 bmem_rvalid_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_COLLECT
    } state_t;

    state_t                   state;
    logic [XLEN-1:0]          line_addr;
    logic [LINE_BITS-1:0]     line_q;
    logic [BEAT_SEL_BITS-1:0] beat_cnt;
    logic [BEAT_SEL_BITS-1:0] slot;
    logic                     beat_ok;
    logic                     resp_q;

    assign slot    = bmem_raddr_i[OFFSET_BITS-1 -: BEAT_SEL_BITS];
    // stray beats from another line are dropped
    assign beat_ok = (state == S_COLLECT) && bmem_rvalid_i
                     && (bmem_raddr_i[XLEN-1:OFFSET_BITS] == line_addr[XLEN-1:OFFSET_BITS]);

    assign bmem_read_o = (state == S_ISSUE) && bmem_ready_i;
    assign bmem_addr_o = line_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            beat_cnt <= '0;
            resp_q   <= 1'b0;
        end else begin
            resp_q <= 1'b0;
            case (state)
                S_IDLE: begin
                    beat_cnt <= '0;
                    if (fill.read) begin
                        state <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    if (bmem_ready_i) begin
                        state <= S_COLLECT;
                    end
                end
                S_COLLECT: begin
                    if (beat_ok) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == BEAT_SEL_BITS'(BEATS_PER_LINE - 1)) begin
                            resp_q <= 1'b1;    // last beat in
                            state  <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && fill.read) begin
            line_addr <= fill.addr;
        end
        if (beat_ok) begin
            line_q[slot*BEAT_BITS +: BEAT_BITS] <= bmem_rdata_i;
        end
    end

    assign fill.resp = resp_q;
    assign fill.line = line_q;

endmodule

//--- rtl/instr_queue.sv
`timescale 1ns/1ps

module instr_queue
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    enq_if.consumer    queue,
    output logic       instr_valid_o,
    output fetch_pkt_t instr_pkt_o,
    input  logic       instr_ready_i
);

    fetch_pkt_t           mem [QUEUE_DEPTH];
    logic [QPTR_BITS-1:0] wr_ptr;
    logic [QPTR_BITS-1:0] rd_ptr;
    logic [QPTR_BITS:0]   count;
    logic                 push;
    logic                 pop;

    assign queue.full    = (count == (QPTR_BITS + 1)'(QUEUE_DEPTH));
    assign instr_valid_o = (count != '0);
    assign instr_pkt_o   = mem[rd_ptr];

    assign push = queue.enq && !queue.full && !queue.flush;
    assign pop  = instr_valid_o && instr_ready_i;

    always_ff @(posedge clk) begin
        if (rst || queue.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (QPTR_BITS + 1)'(push) - (QPTR_BITS + 1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= queue.pkt;
        end
    end

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 redirect_i,
    input  logic [XLEN-1:0]      redirect_pc_i,

    output logic [XLEN-1:0]      bmem_addr_o,
    output logic                 bmem_read_o,
    input  logic                 bmem_ready_i,
    input  logic [XLEN-1:0]      bmem_raddr_i,
    input  logic [BEAT_BITS-1:0] bmem_rdata_i,
    input  logic                 bmem_rvalid_i,

    output logic                 instr_valid_o,
    output logic [XLEN-1:0]      instr_pc_o,
    output logic [XLEN-1:0]      instr_data_o,
    input  logic                 instr_ready_i
);

    icache_if cache_bus ();
    fill_if   fill_bus ();
    enq_if    enq_bus ();

    fetch_pkt_t instr_pkt;

    fetch_unit i_fetch_unit (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .cache         (cache_bus),
        .queue         (enq_bus)
    );

    icache i_icache (
        .clk   (clk),
        .rst   (rst),
        .cache (cache_bus),
        .fill  (fill_bus)
    );

    line_deserializer i_line_deserializer (
        .clk           (clk),
        .rst           (rst),
        .fill          (fill_bus),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

    instr_queue i_instr_queue (
        .clk           (clk),
        .rst           (rst),
        .queue         (enq_bus),
        .instr_valid_o (instr_valid_o),
        .instr_pkt_o   (instr_pkt),
        .instr_ready_i (instr_ready_i)
    );

    // split packet for the consumer
    assign instr_pc_o   = instr_pkt.pc;
    assign instr_data_o = instr_pkt.instr;

endmodule

//--- verification/fetch_top_sva.sv
`timescale 1ns/1ps

module fetch_top_sva (
    input logic clk,
    input logic rst,
    input logic bmem_read_i,
    input logic bmem_ready_i,
    input logic instr_valid_i,
    input logic enq_i,
    input logic full_i
);

    a_read_pulse: assert property (
        @(posedge clk) disable iff (rst) bmem_read_i |=> !bmem_read_i
    ) else $error("bmem read held for more than one cycle");

    a_read_ready: assert property (
        @(posedge clk) disable iff (rst) bmem_read_i |-> bmem_ready_i
    ) else $error("bmem read issued while memory not ready");

    a_enq_full: assert property (
        @(posedge clk) disable iff (rst) enq_i |-> !full_i
    ) else $error("enqueue while queue full");

    // first cycle out of reset
    a_reset_idle: assert property (
        @(posedge clk) $fell(rst) |-> !bmem_read_i && !instr_valid_i
    ) else $error("outputs active right after reset");

endmodule

bind fetch_top fetch_top_sva i_fetch_top_sva (
    .clk           (clk),
    .rst           (rst),
    .bmem_read_i   (bmem_read_o),
    .bmem_ready_i  (bmem_ready_i),
    .instr_valid_i (instr_valid_o),
    .enq_i         (enq_bus.enq),
    .full_i        (enq_bus.full)
);

//--- verification/fetch_top_tb.sv
`timescale 1ns/1ps

module fetch_top_tb
    import fetch_pkg::*;
();

    localparam int WAIT_LIMIT = 500;    // cycles per wait

    typedef struct {
        string           name;
        logic [XLEN-1:0] early_pc;       // zero or an earlier redirect the row's own cuts short
        logic [XLEN-1:0] redirect_pc;    // 0 for none
        int              packets;
        bit              rand_ready;
        int              new_reads;
    } row_t;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 redirect_i;
    logic [XLEN-1:0]      redirect_pc_i;
    logic [XLEN-1:0]      bmem_addr_o;
    logic                 bmem_read_o;
    logic                 bmem_ready_i = 1'b0;
    logic [XLEN-1:0]      bmem_raddr_i = '0;
    logic [BEAT_BITS-1:0] bmem_rdata_i = '0;
    logic                 bmem_rvalid_i = 1'b0;
    logic                 instr_valid_o;
    logic [XLEN-1:0]      instr_pc_o;
    logic [XLEN-1:0]      instr_data_o;
    logic                 instr_ready_i;

    row_t            rows[$];
    logic [XLEN-1:0] exp_pc;
    int              read_count = 0;

    fetch_top i_fetch_top (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        #1;
        bmem_ready_i = ($urandom_range(0, 3) != 0);    // busy one cycle in four
    end

    function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-1:0] addr);
        return addr ^ 32'h1357_9bdf;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_equal(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // ascending beats with stray foreign beats in the gaps
    task automatic serve_line(input logic [XLEN-1:0] base);
        logic [XLEN-1:0] addr;
        for (int b = 0; b < BEATS_PER_LINE; b++) begin
            repeat ($urandom_range(0, 4)) begin
                @(posedge clk);
                #1;
                bmem_rvalid_i = ($urandom_range(0, 1) == 1);
                bmem_raddr_i  = (base ^ 32'h0000_0400) + ($urandom_range(0, 3) << 3);
                bmem_rdata_i  = {$urandom, $urandom};
            end
            @(posedge clk);
            #1;
            addr          = base + 32'(b * 8);
            bmem_rvalid_i = 1'b1;
            bmem_raddr_i  = addr;
            bmem_rdata_i  = {mem_word(addr + 32'd4), mem_word(addr)};
        end
        @(posedge clk);
        #1;
        bmem_rvalid_i = 1'b0;
    endtask

    always begin
        @(negedge clk);
        if (bmem_read_o) begin
            read_count++;
            serve_line(bmem_addr_o);
        end
    end

    task automatic add_row(input string name, input logic [XLEN-1:0] early_pc,
                           input logic [XLEN-1:0] redirect_pc, input int packets,
                           input bit rand_ready, input int new_reads);
        row_t row;
        row.name        = name;
        row.early_pc    = early_pc;
        row.redirect_pc = redirect_pc;
        row.packets     = packets;
        row.rand_ready  = rand_ready;
        row.new_reads   = new_reads;
        rows.push_back(row);
    endtask

    task automatic issue_redirect(input logic [XLEN-1:0] pc);
        redirect_i    = 1'b1;
        redirect_pc_i = pc;
        instr_ready_i = 1'b0;    // nothing taken in the flush cycle
        @(posedge clk);
        #1;
        redirect_i = 1'b0;
        exp_pc     = pc;
    endtask

    task automatic consume_packets(input string name, input int packets, input bit rand_ready);
        int got;
        int idle;
        got  = 0;
        idle = 0;
        while (got < packets) begin
            instr_ready_i = rand_ready ? ($urandom_range(0, 1) == 1) : 1'b1;
            @(negedge clk);
            if (instr_valid_o && instr_ready_i) begin
                check_equal({name, " pc"}, exp_pc, instr_pc_o);
                check_equal({name, " data"}, mem_word(exp_pc), instr_data_o);
                exp_pc = exp_pc + 32'd4;
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > WAIT_LIMIT) begin
                    fail_run($sformatf("timeout in %s waiting for packet %0d", name, got));
                end
            end
            @(posedge clk);
            #1;
        end
        instr_ready_i = 1'b0;
    endtask

    task automatic wait_for_read(input string name, input int reads_before);
        int cycles;
        cycles = 0;
        while (read_count == reads_before) begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                fail_run($sformatf("timeout in %s waiting for a memory read", name));
            end
        end
        #1;
    endtask

    // rest means a full queue and no cache request for two cycles
    task automatic wait_for_rest(input string name);
        int cycles;
        int calm;
        cycles = 0;
        calm   = 0;
        while (calm < 2) begin
            @(negedge clk);
            if (32'(i_fetch_top.i_instr_queue.count) == QUEUE_DEPTH
                && !i_fetch_top.i_fetch_unit.req_q) begin
                calm++;
            end else begin
                calm = 0;
            end
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                fail_run($sformatf("timeout in %s waiting for the front end to settle", name));
            end
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        int reads_before;
        void'($urandom(32'hbe17f897));
        rst           = 1'b1;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        instr_ready_i = 1'b0;
        exp_pc        = RESET_PC;

        // name, early redirect, redirect, packets, random ready, new memory reads
        add_row("reset_fetch",      32'h0,    32'h0,    1,  1'b0, 2);
        add_row("seq_lines",        32'h0,    32'h0,    20, 1'b0, 2);
        add_row("backpressure",     32'h0,    32'h0,    24, 1'b1, 3);
        add_row("redirect_hit",     32'h0,    32'h1008, 10, 1'b0, 0);
        add_row("alias_set",        32'h0,    32'h1200, 12, 1'b1, 3);
        add_row("redirect_in_miss", 32'h2000, 32'h3010, 8,  1'b0, 4);
        add_row("long_stream",      32'h0,    32'h0,    30, 1'b1, 4);

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_equal("reset valid", 32'd0, 32'(instr_valid_o));
        check_equal("reset read", 32'd0, 32'(bmem_read_o));
        @(posedge clk);
        #1;

        foreach (rows[i]) begin
            reads_before = read_count;
            if (rows[i].early_pc != '0) begin
                issue_redirect(rows[i].early_pc);
                wait_for_read(rows[i].name, reads_before);
            end
            if (rows[i].redirect_pc != '0) begin
                issue_redirect(rows[i].redirect_pc);
            end
            consume_packets(rows[i].name, rows[i].packets, rows[i].rand_ready);
            wait_for_rest(rows[i].name);
            check_equal({rows[i].name, " reads"}, rows[i].new_reads, read_count - reads_before);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- compile.f
rtl/fetch_pkg.sv
rtl/fetch_ifs.sv
rtl/fetch_unit.sv
rtl/icache.sv
rtl/line_deserializer.sv
rtl/instr_queue.sv
rtl/fetch_top.sv
verification/fetch_top_sva.sv
verification/fetch_top_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fetch_top_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
